// File: ex_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage shared types
////////////////////////////////////////////////////////////////////////////

package ex_pkg;

  // Datapath and register file widths
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;

  // Operand, result and CSR data word
  typedef logic [XLEN-1:0]       word_t;
  // Integer register file address
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ALU operations, comparisons in the upper half
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Multiplier operations
  typedef enum logic [1:0] {
    MUL_LO,
    MUL_H,
    MUL_HSU,
    MUL_HU
  } mult_op_e;

  // Iterative high-product FSM
  typedef enum logic [1:0] {
    MULT_IDLE,
    MULT_BUSY,
    MULT_DONE
  } mult_state_e;

  // One register file write, 38 bits
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
  } wr_port_t;

endpackage

// File: ex_alu.sv
////////////////////////////////////////////////////////////////////////////
// Integer ALU
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_alu (
  input  ex_pkg::alu_op_e alu_operator_i,
  input  ex_pkg::word_t   alu_operand_a_i,
  input  ex_pkg::word_t   alu_operand_b_i,
  output ex_pkg::word_t   result_o,
  output logic            cmp_result_o
);

  import ex_pkg::*;

  localparam int unsigned SHAMT_W = $clog2(XLEN);

  logic               sub_en;
  word_t              adder_b;
  logic [XLEN:0]      adder_sum;
  logic               lt_unsigned;
  logic               lt_signed;
  logic               equal;
  logic [SHAMT_W-1:0] shamt;
  logic               cmp;

  // Only ADD uses a plain sum, everything else subtracts
  assign sub_en  = (alu_operator_i != ALU_ADD);
  assign adder_b = sub_en ? ~alu_operand_b_i : alu_operand_b_i;

  // Carry out lands in the top bit
  assign adder_sum = {1'b0, alu_operand_a_i} + {1'b0, adder_b} + {{XLEN{1'b0}}, sub_en};

  ////////////////////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////////////////////

  // No carry out of a - b means a < b unsigned
  assign lt_unsigned = ~adder_sum[XLEN];
  // Differing signs decide directly, else same as unsigned
  assign lt_signed   = (alu_operand_a_i[XLEN-1] ^ alu_operand_b_i[XLEN-1]) ?
                       alu_operand_a_i[XLEN-1] : lt_unsigned;
  assign equal       = (alu_operand_a_i == alu_operand_b_i);

  // Shared between SLT and branch compares
  always_comb begin
    unique case (alu_operator_i)
      ALU_SLT,  ALU_LT:  cmp = lt_signed;
      ALU_SLTU, ALU_LTU: cmp = lt_unsigned;
      ALU_EQ:            cmp = equal;
      ALU_NE:            cmp = ~equal;
      ALU_GE:            cmp = ~lt_signed;
      ALU_GEU:           cmp = ~lt_unsigned;
      default:           cmp = 1'b0;
    endcase
  end

  assign cmp_result_o = cmp;

  ////////////////////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////////////////////

  // Shift amount from low bits of b
  assign shamt = alu_operand_b_i[SHAMT_W-1:0];

  always_comb begin
    unique case (alu_operator_i)
      ALU_ADD, ALU_SUB: result_o = adder_sum[XLEN-1:0];
      ALU_AND:          result_o = alu_operand_a_i & alu_operand_b_i;
      ALU_OR:           result_o = alu_operand_a_i | alu_operand_b_i;
      ALU_XOR:          result_o = alu_operand_a_i ^ alu_operand_b_i;
      ALU_SLL:          result_o = alu_operand_a_i << shamt;
      ALU_SRL:          result_o = alu_operand_a_i >> shamt;
      ALU_SRA:          result_o = word_t'($signed(alu_operand_a_i) >>> shamt);
      // Comparisons give the zero-extended flag
      default:          result_o = {{(XLEN-1){1'b0}}, cmp};
    endcase
  end

endmodule

// File: ex_mult.sv
////////////////////////////////////////////////////////////////////////////
// Integer multiplier
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_mult #(
  parameter int unsigned MULT_BITS_PER_CYCLE = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             enable_i,
  input  ex_pkg::mult_op_e operator_i,
  input  ex_pkg::word_t    op_a_i,
  input  ex_pkg::word_t    op_b_i,
  input  logic             ex_ready_i,
  output ex_pkg::word_t    result_o,
  output logic             ready_o,
  output logic             multicycle_o
);

  import ex_pkg::*;

  localparam int unsigned STEPS = XLEN / MULT_BITS_PER_CYCLE;
  localparam int unsigned CNT_W = $clog2(STEPS);

  // Full 64-bit product and accumulator
  typedef logic [2*XLEN-1:0] acc_t;

  mult_state_e                  state_q, state_d;
  logic [CNT_W-1:0]             cnt_q;
  acc_t                         acc_q, a_q;
  word_t                        b_q;
  logic                         b_signed_q;

  logic                         start;
  logic                         a_signed;
  acc_t                         a_ext;
  acc_t                         step_a, step_acc, partial, acc_next;
  word_t                        step_b;
  logic                         step_b_signed;
  logic                         step_last;
  logic [MULT_BITS_PER_CYCLE:0] chunk_ext;

  // High product requested while idle
  assign start    = enable_i && (operator_i != MUL_LO) && (state_q == MULT_IDLE);
  // HU is the only high op with unsigned a
  assign a_signed = (operator_i != MUL_HU);
  assign a_ext    = {{XLEN{a_signed & op_a_i[XLEN-1]}}, op_a_i};

  ////////////////////////////////////////////////////////////////////////////
  // Step datapath
  ////////////////////////////////////////////////////////////////////////////

  // First chunk is taken in the idle cycle, straight from the inputs
  assign step_a        = (state_q == MULT_IDLE) ? a_ext : a_q;
  assign step_b        = (state_q == MULT_IDLE) ? op_b_i : b_q;
  assign step_acc      = (state_q == MULT_IDLE) ? '0 : acc_q;
  assign step_b_signed = (state_q == MULT_IDLE) ? (operator_i == MUL_H) : b_signed_q;
  assign step_last     = (state_q == MULT_BUSY) && (cnt_q == CNT_W'(STEPS - 1));

  // Top chunk of a signed b carries negative weight
  assign chunk_ext = {step_b_signed & step_last & step_b[MULT_BITS_PER_CYCLE-1],
                      step_b[MULT_BITS_PER_CYCLE-1:0]};

  // Truncated to 64 bits, which is exact modulo 2^64
  assign partial  = $signed(step_a) * $signed(chunk_ext);
  assign acc_next = step_acc + partial;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      MULT_IDLE: if (start)      state_d = MULT_BUSY;
      MULT_BUSY: if (step_last)  state_d = MULT_DONE;
      // Hold the result until the stage moves on
      MULT_DONE: if (ex_ready_i) state_d = MULT_IDLE;
      default:                   state_d = MULT_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MULT_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (start) begin
        cnt_q <= CNT_W'(1);
      end else if (state_q == MULT_BUSY) begin
        cnt_q <= cnt_q + CNT_W'(1);
      end
    end
  end

  // Operand shifters and accumulator
  always_ff @(posedge clk) begin
    if (start || (state_q == MULT_BUSY)) begin
      a_q   <= step_a << MULT_BITS_PER_CYCLE;
      b_q   <= step_b >> MULT_BITS_PER_CYCLE;
      acc_q <= acc_next;
    end
    if (start) begin
      b_signed_q <= step_b_signed;
    end
  end

  // Low word is single cycle
  assign result_o     = (state_q == MULT_DONE) ? acc_q[2*XLEN-1:XLEN] : word_t'(op_a_i * op_b_i);
  assign ready_o      = (state_q == MULT_DONE) || ((state_q == MULT_IDLE) && !start);
  assign multicycle_o = (state_q == MULT_DONE);

endmodule

// File: ex_writeback.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage write ports and stall logic
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_writeback (
  input  logic              clk,
  input  logic              rst_n,

  // Unit enables
  input  logic              alu_en_i,
  input  logic              mult_en_i,
  input  logic              csr_access_i,
  input  logic              lsu_en_i,

  // Results
  input  ex_pkg::word_t     alu_result_i,
  input  ex_pkg::word_t     mult_result_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  ex_pkg::word_t     lsu_rdata_i,

  // Register write controls from ID
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,

  // Stall inputs
  input  logic              mult_ready_i,
  input  logic              lsu_ready_ex_i,
  input  logic              wb_ready_i,
  input  logic              branch_in_ex_i,

  output ex_pkg::wr_port_t  fw_port_o,
  output ex_pkg::wr_port_t  wb_port_o,
  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  logic      regfile_we_lsu_q;
  reg_addr_t regfile_waddr_lsu_q;
  logic      units_ready;
  logic      any_unit_en;

  ////////////////////////////////////////////////////////////////////////////
  // Forwarding port
  ////////////////////////////////////////////////////////////////////////////

  // Later assignment wins, CSR over mult over ALU
  always_comb begin
    fw_port_o.we    = regfile_alu_we_i;
    fw_port_o.waddr = regfile_alu_waddr_i;
    fw_port_o.wdata = '0;
    if (alu_en_i) begin
      fw_port_o.wdata = alu_result_i;
    end
    if (mult_en_i) begin
      fw_port_o.wdata = mult_result_i;
    end
    if (csr_access_i) begin
      fw_port_o.wdata = csr_rdata_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB pipeline register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regfile_we_lsu_q    <= 1'b0;
      regfile_waddr_lsu_q <= '0;
    end else if (ex_valid_o) begin
      // WB ready is implied by valid
      regfile_we_lsu_q <= regfile_we_i;
      if (regfile_we_i) begin
        regfile_waddr_lsu_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // Nothing new arrived, drain the old write
      regfile_we_lsu_q <= 1'b0;
    end
  end

  // Load data comes back from the LSU a cycle later
  assign wb_port_o.we    = regfile_we_lsu_q;
  assign wb_port_o.waddr = regfile_waddr_lsu_q;
  assign wb_port_o.wdata = lsu_rdata_i;

  ////////////////////////////////////////////////////////////////////////////
  // Stall control
  ////////////////////////////////////////////////////////////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;
  assign any_unit_en = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches finish in EX, so they never wait on WB
  assign ex_ready_o = units_ready | branch_in_ex_i;
  // Valid does not look at ex_ready
  assign ex_valid_o = any_unit_en & units_ready;

endmodule

// File: ex_stage.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ex_stage #(
  parameter int unsigned MULT_BITS_PER_CYCLE = 8
) (
  input  logic              clk,
  input  logic              rst_n,

  // ALU operands from ID
  input  logic              alu_en_i,
  input  ex_pkg::alu_op_e   alu_operator_i,
  input  ex_pkg::word_t     alu_operand_a_i,
  input  ex_pkg::word_t     alu_operand_b_i,
  input  ex_pkg::word_t     alu_operand_c_i,

  // Multiplier operands from ID
  input  logic              mult_en_i,
  input  ex_pkg::mult_op_e  mult_operator_i,
  input  ex_pkg::word_t     mult_operand_a_i,
  input  ex_pkg::word_t     mult_operand_b_i,
  output logic              mult_multicycle_o,

  // CSR and load data
  input  logic              csr_access_i,
  input  ex_pkg::word_t     csr_rdata_i,
  input  logic              lsu_en_i,
  input  ex_pkg::word_t     lsu_rdata_i,

  // Register write controls
  input  logic              regfile_alu_we_i,
  input  ex_pkg::reg_addr_t regfile_alu_waddr_i,
  input  logic              regfile_we_i,
  input  ex_pkg::reg_addr_t regfile_waddr_i,

  // Stall inputs
  input  logic              branch_in_ex_i,
  input  logic              lsu_ready_ex_i,
  input  logic              wb_ready_i,

  output ex_pkg::wr_port_t  fw_port_o,
  output ex_pkg::wr_port_t  wb_port_o,

  // Branch resolution to IF
  output ex_pkg::word_t     jump_target_o,
  output logic              branch_decision_o,

  output logic              ex_ready_o,
  output logic              ex_valid_o
);

  import ex_pkg::*;

  word_t alu_result;
  word_t mult_result;
  logic  alu_cmp_result;
  logic  mult_ready;

  // Branch target is precomputed in ID as operand c
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  ex_alu u_alu (
    .alu_operator_i  (alu_operator_i),
    .alu_operand_a_i (alu_operand_a_i),
    .alu_operand_b_i (alu_operand_b_i),
    .result_o        (alu_result),
    .cmp_result_o    (alu_cmp_result)
  );

  ex_mult #(
    .MULT_BITS_PER_CYCLE (MULT_BITS_PER_CYCLE)
  ) u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback u_writeback (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en_i),
    .mult_en_i           (mult_en_i),
    .csr_access_i        (csr_access_i),
    .lsu_en_i            (lsu_en_i),
    .alu_result_i        (alu_result),
    .mult_result_i       (mult_result),
    .csr_rdata_i         (csr_rdata_i),
    .lsu_rdata_i         (lsu_rdata_i),
    .regfile_alu_we_i    (regfile_alu_we_i),
    .regfile_alu_waddr_i (regfile_alu_waddr_i),
    .regfile_we_i        (regfile_we_i),
    .regfile_waddr_i     (regfile_waddr_i),
    .mult_ready_i        (mult_ready),
    .lsu_ready_ex_i      (lsu_ready_ex_i),
    .wb_ready_i          (wb_ready_i),
    .branch_in_ex_i      (branch_in_ex_i),
    .fw_port_o           (fw_port_o),
    .wb_port_o           (wb_port_o),
    .ex_ready_o          (ex_ready_o),
    .ex_valid_o          (ex_valid_o)
  );

endmodule

// File: tb_ex_ref.svh
////////////////////////////////////////////////////////////////////////////
// Execute stage reference model
////////////////////////////////////////////////////////////////////////////

`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

// LCG step, upper halves of two steps make one word
function automatic word_t rand_word();
  logic [31:0] first;
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  first = lcg_state;
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return {first[31:16], lcg_state[31:16]};
endfunction

// Comparison outcome, zero for non-comparisons
function automatic logic ref_cmp(alu_op_e op, word_t a, word_t b);
  case (op)
    ALU_SLT, ALU_LT:   return $signed(a) < $signed(b);
    ALU_SLTU, ALU_LTU: return a < b;
    ALU_EQ:            return a == b;
    ALU_NE:            return a != b;
    ALU_GE:            return $signed(a) >= $signed(b);
    ALU_GEU:           return a >= b;
    default:           return 1'b0;
  endcase
endfunction

function automatic word_t ref_alu(alu_op_e op, word_t a, word_t b);
  case (op)
    ALU_ADD: return a + b;
    ALU_SUB: return a - b;
    ALU_AND: return a & b;
    ALU_OR:  return a | b;
    ALU_XOR: return a ^ b;
    ALU_SLL: return a << b[4:0];
    ALU_SRL: return a >> b[4:0];
    ALU_SRA: return $signed(a) >>> b[4:0];
    default: return word_t'(ref_cmp(op, a, b));
  endcase
endfunction

// Extend to 64 bits, product is exact modulo 2^64
function automatic word_t ref_mult(mult_op_e op, word_t a, word_t b);
  logic [63:0] a_ext;
  logic [63:0] b_ext;
  logic [63:0] prod;
  a_ext = {{32{a[31] && (op != MUL_HU)}}, a};
  b_ext = {{32{b[31] && (op == MUL_H)}}, b};
  prod  = a_ext * b_ext;
  return (op == MUL_LO) ? prod[31:0] : prod[63:32];
endfunction

task automatic check_word(word_t got, word_t exp, string what);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_port(wr_port_t got, wr_port_t exp, string what);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("Fail %0t: %s is we=%b waddr=%0d data=%h, expected we=%b waddr=%0d data=%h",
             $time, what, got.we, got.waddr, got.wdata, exp.we, exp.waddr, exp.wdata);
  end
endtask

task automatic check_bit(logic got, logic exp, string what);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

`endif

// File: tb_ex_stage.sv
////////////////////////////////////////////////////////////////////////////
// Execute stage testbench
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_ex_stage;

  import ex_pkg::*;

  localparam int unsigned MULT_BITS_PER_CYCLE = 8;
  localparam int unsigned MUL_CYCLES = XLEN / MULT_BITS_PER_CYCLE;
  localparam int CLK_PERIOD = 4;
  localparam int N_ALU  = 120;
  localparam int N_MUL  = 32;
  localparam int N_MISC = 16;
  // Every operation gets the worst multiply latency plus slack
  localparam int TIMEOUT_CYCLES = (N_ALU + N_MUL + N_MISC) * (MUL_CYCLES + 4) + 100;

  logic      clk;
  logic      rst_n;
  logic      alu_en;
  alu_op_e   alu_operator;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_c;
  logic      mult_en;
  mult_op_e  mult_operator;
  word_t     mult_a;
  word_t     mult_b;
  logic      mult_multicycle;
  logic      csr_access;
  word_t     csr_rdata;
  logic      lsu_en;
  word_t     lsu_rdata;
  logic      regfile_alu_we;
  reg_addr_t regfile_alu_waddr;
  logic      regfile_we;
  reg_addr_t regfile_waddr;
  logic      branch_in_ex;
  logic      lsu_ready_ex;
  logic      wb_ready;
  wr_port_t  fw_port;
  wr_port_t  wb_port;
  word_t     jump_target;
  logic      branch_decision;
  logic      ex_ready;
  logic      ex_valid;

  // Expected values handed to the compare process
  logic      exp_fw_en;
  wr_port_t  exp_fw;
  logic      exp_br_en;
  logic      exp_br;
  word_t     exp_target;

  logic [31:0] lcg_state;
  int          n_checks;
  int          n_errors;

  `include "tb_ex_ref.svh"

  ex_stage #(
    .MULT_BITS_PER_CYCLE (MULT_BITS_PER_CYCLE)
  ) u_ex_stage (
    .clk                 (clk),
    .rst_n               (rst_n),
    .alu_en_i            (alu_en),
    .alu_operator_i      (alu_operator),
    .alu_operand_a_i     (alu_a),
    .alu_operand_b_i     (alu_b),
    .alu_operand_c_i     (alu_c),
    .mult_en_i           (mult_en),
    .mult_operator_i     (mult_operator),
    .mult_operand_a_i    (mult_a),
    .mult_operand_b_i    (mult_b),
    .mult_multicycle_o   (mult_multicycle),
    .csr_access_i        (csr_access),
    .csr_rdata_i         (csr_rdata),
    .lsu_en_i            (lsu_en),
    .lsu_rdata_i         (lsu_rdata),
    .regfile_alu_we_i    (regfile_alu_we),
    .regfile_alu_waddr_i (regfile_alu_waddr),
    .regfile_we_i        (regfile_we),
    .regfile_waddr_i     (regfile_waddr),
    .branch_in_ex_i      (branch_in_ex),
    .lsu_ready_ex_i      (lsu_ready_ex),
    .wb_ready_i          (wb_ready),
    .fw_port_o           (fw_port),
    .wb_port_o           (wb_port),
    .jump_target_o       (jump_target),
    .branch_decision_o   (branch_decision),
    .ex_ready_o          (ex_ready),
    .ex_valid_o          (ex_valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Outputs are settled by the falling edge
  always @(negedge clk) begin
    if (rst_n === 1'b1 && exp_fw_en && ex_valid) begin
      check_port(fw_port, exp_fw, "forwarding port");
    end
    if (rst_n === 1'b1 && exp_br_en) begin
      check_bit(branch_decision, exp_br, "branch decision");
      check_word(jump_target, exp_target, "jump target");
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  task automatic next_slot();
    @(posedge clk);
    #0.5;
  endtask

  // Nothing enabled, all downstream units ready
  task automatic drive_idle();
    alu_en            = 1'b0;
    alu_operator      = ALU_ADD;
    alu_a             = '0;
    alu_b             = '0;
    alu_c             = '0;
    mult_en           = 1'b0;
    mult_operator     = MUL_LO;
    mult_a            = '0;
    mult_b            = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    lsu_en            = 1'b0;
    lsu_rdata         = '0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    branch_in_ex      = 1'b0;
    lsu_ready_ex      = 1'b1;
    wb_ready          = 1'b1;
    exp_fw_en         = 1'b0;
    exp_br_en         = 1'b0;
  endtask

  task automatic run_alu_ops();
    word_t r;
    for (int i = 0; i < N_ALU; i++) begin
      next_slot();
      drive_idle();
      r = rand_word();
      alu_en            = 1'b1;
      alu_operator      = alu_op_e'(r[3:0]);
      regfile_alu_we    = r[4];
      regfile_alu_waddr = r[9:5];
      alu_a             = rand_word();
      // Equal operands now and then so EQ and NE both resolve true
      alu_b             = (r[12:10] == 3'd0) ? alu_a : rand_word();
      alu_c             = rand_word();
      exp_fw     = {regfile_alu_we, regfile_alu_waddr, ref_alu(alu_operator, alu_a, alu_b)};
      exp_br     = ref_cmp(alu_operator, alu_a, alu_b);
      exp_target = alu_c;
      exp_fw_en  = 1'b1;
      exp_br_en  = 1'b1;
      @(negedge clk);
      check_bit(ex_valid, 1'b1, "ex_valid for ALU op");
    end
  endtask

  task automatic run_mult_ops();
    word_t r;
    int    low_cycles;
    int    exp_low;
    for (int i = 0; i < N_MUL; i++) begin
      next_slot();
      drive_idle();
      r = rand_word();
      mult_en           = 1'b1;
      mult_operator     = mult_op_e'(r[1:0]);
      regfile_alu_we    = 1'b1;
      regfile_alu_waddr = r[6:2];
      mult_a            = rand_word();
      mult_b            = rand_word();
      // Sign corner cases first
      if (i < 8) begin
        mult_operator = mult_op_e'(i[1:0]);
        mult_a        = i[2] ? 32'hffff_ffff : 32'h8000_0000;
        mult_b        = i[0] ? 32'hffff_ffff : 32'h8000_0000;
      end
      exp_fw    = {1'b1, regfile_alu_waddr, ref_mult(mult_operator, mult_a, mult_b)};
      exp_fw_en = 1'b1;
      exp_low   = (mult_operator == MUL_LO) ? 0 : MUL_CYCLES;
      low_cycles = 0;
      @(negedge clk);
      while (!ex_valid && low_cycles <= exp_low + 4) begin
        low_cycles++;
        @(negedge clk);
      end
      if (!ex_valid) begin
        n_errors++;
        $display("Multiply %0d never raised ex_valid", i);
      end else if (low_cycles != exp_low) begin
        n_errors++;
        $display("Fail %0t: multiply stalled %0d cycles, expected %0d",
                 $time, low_cycles, exp_low);
      end
      check_bit(mult_multicycle, mult_operator != MUL_LO, "mult multicycle flag");
    end
  endtask

  task automatic run_fw_priority();
    // CSR data wins over the ALU
    next_slot();
    drive_idle();
    alu_en            = 1'b1;
    alu_a             = rand_word();
    alu_b             = rand_word();
    csr_access        = 1'b1;
    csr_rdata         = rand_word();
    regfile_alu_we    = 1'b1;
    regfile_alu_waddr = 5'd7;
    exp_fw            = {1'b1, 5'd7, csr_rdata};
    exp_fw_en         = 1'b1;
    @(negedge clk);
    check_bit(ex_valid, 1'b1, "ex_valid for CSR access");
    // Multiplier wins over the ALU
    next_slot();
    drive_idle();
    alu_en    = 1'b1;
    alu_a     = rand_word();
    mult_en   = 1'b1;
    mult_a    = rand_word();
    mult_b    = rand_word();
    exp_fw    = {1'b0, 5'd0, ref_mult(MUL_LO, mult_a, mult_b)};
    exp_fw_en = 1'b1;
    @(negedge clk);
    check_bit(ex_valid, 1'b1, "ex_valid for mult over ALU");
    next_slot();
    drive_idle();
    alu_a             = rand_word();
    regfile_alu_we    = 1'b1;
    regfile_alu_waddr = 5'd3;
    @(negedge clk);
    check_port(fw_port, {1'b1, 5'd3, 32'h0}, "idle forwarding port");
    check_bit(ex_valid, 1'b0, "ex_valid with nothing enabled");
  endtask

  task automatic run_load_port();
    next_slot();
    drive_idle();
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = 5'd19;
    @(negedge clk);
    check_bit(ex_valid, 1'b1, "ex_valid for load");
    // Back to back load without a write
    next_slot();
    drive_idle();
    lsu_en        = 1'b1;
    regfile_waddr = 5'd4;
    lsu_rdata     = rand_word();
    @(negedge clk);
    check_port(wb_port, {1'b1, 5'd19, lsu_rdata}, "load port after write");
    next_slot();
    drive_idle();
    lsu_rdata = rand_word();
    @(negedge clk);
    check_port(wb_port, {1'b0, 5'd19, lsu_rdata}, "load port after load without write");
  endtask

  task automatic run_back_pressure();
    next_slot();
    drive_idle();
    lsu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = 5'd11;
    next_slot();
    drive_idle();
    wb_ready      = 1'b0;
    alu_en        = 1'b1;
    regfile_we    = 1'b1;
    regfile_waddr = 5'd22;
    lsu_rdata     = rand_word();
    repeat (3) begin
      @(negedge clk);
      check_bit(ex_valid, 1'b0, "ex_valid under WB stall");
      check_bit(ex_ready, 1'b0, "ex_ready under WB stall");
      check_port(wb_port, {1'b1, 5'd11, lsu_rdata}, "held load port");
    end
    // LSU stall, WB ready so the old write drains at the edge
    next_slot();
    wb_ready     = 1'b1;
    lsu_ready_ex = 1'b0;
    @(negedge clk);
    check_bit(ex_valid, 1'b0, "ex_valid under LSU stall");
    check_port(wb_port, {1'b1, 5'd11, lsu_rdata}, "load port under LSU stall");
    next_slot();
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b0;
    branch_in_ex = 1'b1;
    @(negedge clk);
    check_bit(ex_ready, 1'b1, "ex_ready with branch in EX");
    check_bit(ex_valid, 1'b0, "ex_valid with branch under WB stall");
    check_port(wb_port, {1'b0, 5'd11, lsu_rdata}, "drained load port");
    next_slot();
    wb_ready     = 1'b1;
    branch_in_ex = 1'b0;
    @(negedge clk);
    check_bit(ex_valid, 1'b1, "ex_valid after release");
    next_slot();
    drive_idle();
    @(negedge clk);
    check_port(wb_port, {1'b1, 5'd22, 32'h0}, "load port after release");
  endtask

  initial begin
    lcg_state = 32'd17859;
    n_checks  = 0;
    n_errors  = 0;
    rst_n     = 1'b0;
    drive_idle();
    repeat (2) @(posedge clk);
    #0.5;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit(wb_port.we, 1'b0, "load port we after reset");
    check_bit(mult_multicycle, 1'b0, "mult multicycle after reset");
    run_alu_ops();
    run_mult_ops();
    run_fw_priority();
    run_load_port();
    run_back_pressure();
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+.
ex_pkg.sv
ex_alu.sv
ex_mult.sv
ex_writeback.sv
ex_stage.sv
tb_ex_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module tb_ex_stage -f verilog.f -o tb_ex_stage; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_ex_stage)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "Done: no errors"; then
  exit 0
fi
exit 1
